// File: dzPkg.sv
// Shared sizes and encodings for the four-line terminal multiplexer
// SiloDepth must be a power of two since the silo pointers wrap freely
package dzPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////////////////////////////////////////

   // Terminal lines and line number width
   localparam int NumLines  = 4;
   localparam int LineBits  = 2;

   // Character width
   localparam int CharBits  = 8;

   // Receive silo entries and pointer width
   localparam int SiloDepth = 16;
   localparam int SiloBits  = $clog2(SiloDepth);

   ////////////////////////////////////////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////////////////////////////////////////

   // Word addresses, from PADDR[3:2]
   typedef enum logic [1:0] {
      regCsr  = 2'd0,
      regRbuf = 2'd1,
      regTcr  = 2'd2,
      regTdr  = 2'd3
   } regAddr_t;

   // Rx and tx request machines
   typedef enum logic [1:0] {
      intIdle,
      intAct,
      intWait
   } intState_t;

   // Acknowledge/vector arbiter
   typedef enum logic [2:0] {
      arbIdle,
      arbAck,
      arbVect,
      arbVectClr,
      arbRxDone,
      arbTxDone
   } arbState_t;

endpackage

// File: dzSilo.sv
// Receive silo; one hold register per line, lowest held line moves first
// Overrun is sticky until the next entry is popped
`timescale 1ns/1ns

module dzSilo
(
   input  logic                                        clk,
   input  logic                                        rst,
   input  logic                                        mse,
   input  logic [dzPkg::NumLines-1:0]                  rxStrobe,
   input  logic [dzPkg::NumLines*dzPkg::CharBits-1:0]  rxData,
   input  logic                                        rbufRead,
   output logic                                        siloValid,
   output logic [dzPkg::LineBits-1:0]                  siloLine,
   output logic [dzPkg::CharBits-1:0]                  siloChar,
   output logic                                        siloOverrun
);

   // Per-line hold registers
   logic [dzPkg::NumLines-1:0] holdFull;
   logic [dzPkg::CharBits-1:0] holdChar [dzPkg::NumLines];
   logic [dzPkg::NumLines-1:0] holdLoad;
   logic [dzPkg::NumLines-1:0] holdLost;

   // Priority picker
   logic                       pickValid;
   logic [dzPkg::LineBits-1:0] pickLine;
   logic [dzPkg::NumLines-1:0] drain;

   // Circular FIFO, entry is {line, char}
   logic [dzPkg::LineBits+dzPkg::CharBits-1:0] fifoMem [dzPkg::SiloDepth];
   logic [dzPkg::SiloBits-1:0] wrPtr;
   logic [dzPkg::SiloBits-1:0] rdPtr;
   logic [dzPkg::SiloBits:0]   count;
   logic                       fifoFull;
   logic                       wrEn;
   logic                       pop;
   logic                       drop;

   ////////////////////////////////////////////////////////////////////////////
   // Pick lowest held line, decide per-line capture
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      pickValid = |holdFull;
      pickLine  = '0;
      drain     = '0;
      // Walk downward so line 0 wins
      for (int n = dzPkg::NumLines - 1; n >= 0; n--)
      begin
         if (holdFull[n])
            pickLine = n[dzPkg::LineBits-1:0];
      end
      if (pickValid)
         drain[pickLine] = 1'b1;
      // Full hold register not drained this cycle loses the new char
      holdLoad = {dzPkg::NumLines{mse}} & rxStrobe & (~holdFull | drain);
      holdLost = {dzPkg::NumLines{mse}} & rxStrobe & holdFull & ~drain;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         holdFull <= '0;
      else
         holdFull <= holdLoad | (holdFull & ~drain);
   end

   always_ff @(posedge clk)
   begin
      for (int n = 0; n < dzPkg::NumLines; n++)
      begin
         if (holdLoad[n])
            holdChar[n] <= rxData[n*dzPkg::CharBits +: dzPkg::CharBits];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // FIFO
   ////////////////////////////////////////////////////////////////////////////

   assign fifoFull  = (count == dzPkg::SiloDepth);
   assign pop       = rbufRead && (count != 0);
   // A pop in the same cycle frees the slot
   assign wrEn      = pickValid && (!fifoFull || pop);
   assign drop      = pickValid && !wrEn;

   always_ff @(posedge clk)
   begin
      if (wrEn)
         fifoMem[wrPtr] <= {pickLine, holdChar[pickLine]};
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         wrPtr   <= '0;
         rdPtr   <= '0;
         count   <= '0;
         siloOverrun <= 1'b0;
      end
      else
      begin
         if (wrEn)
            wrPtr <= wrPtr + 1'b1;
         if (pop)
            rdPtr <= rdPtr + 1'b1;
         case ({wrEn, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // New loss wins over the clearing read
         if ((|holdLost) || drop)
            siloOverrun <= 1'b1;
         else if (pop)
            siloOverrun <= 1'b0;
      end
   end

   assign siloValid = (count != 0);
   assign {siloLine, siloChar} = fifoMem[rdPtr];

   // Occupancy bound
   assert property (@(posedge clk) disable iff (rst) count <= dzPkg::SiloDepth);

endmodule

// File: dzTxScan.sv
// Round-robin transmit scanner checking one line per clock
// txData is only meaningful while txStrobe is high
`timescale 1ns/1ns

module dzTxScan
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       mse,
   input  logic [dzPkg::NumLines-1:0] lineEnable,
   input  logic [dzPkg::NumLines-1:0] txReady,
   input  logic                       tdrWrite,
   input  logic [dzPkg::CharBits-1:0] tdrChar,
   output logic                       trdy,
   output logic [dzPkg::LineBits-1:0] tline,
   output logic [dzPkg::NumLines-1:0] txStrobe,
   output logic [dzPkg::CharBits-1:0] txData
);

   // Scan pointer frozen while trdy is set
   logic [dzPkg::LineBits-1:0] scanPtr;
   logic                       lineHit;
   logic                       send;

   // Current line can take a character
   assign lineHit = lineEnable[scanPtr] && txReady[scanPtr];
   // Only a write while a line is offered goes out
   assign send    = tdrWrite && trdy;

   ////////////////////////////////////////////////////////////////////////////
   // Scanner
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         scanPtr <= '0;
         trdy    <= 1'b0;
      end
      else if (!mse)
         trdy <= 1'b0;
      else if (send)
      begin
         // Resume after the line just served
         trdy    <= 1'b0;
         scanPtr <= scanPtr + 1'b1;
      end
      else if (!trdy)
      begin
         if (lineHit)
            trdy <= 1'b1;
         else
            scanPtr <= scanPtr + 1'b1;
      end
   end

   assign tline = scanPtr;

   ////////////////////////////////////////////////////////////////////////////
   // Strobe decode
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         txStrobe <= '0;
      else
      begin
         txStrobe <= '0;
         if (send)
            txStrobe[scanPtr] <= 1'b1;
      end
   end

   // Character for the strobed line
   always_ff @(posedge clk)
   begin
      if (send)
         txData <= tdrChar;
   end

   // Never more than one line strobed
   assert property (@(posedge clk) disable iff (rst) $onehot0(txStrobe));

endmodule

// File: dzIntr.sv
// Rx/tx interrupt requests with acknowledge and vector handshake
// Vector value is produced elsewhere; rx is served before tx
`timescale 1ns/1ns

module dzIntr
(
   input  logic clk,
   input  logic rst,
   input  logic rxReq,
   input  logic txReq,
   input  logic intAck,
   input  logic intVect,
   output logic rxIrq,
   output logic txIrq
);

   dzPkg::intState_t rxState;
   dzPkg::intState_t txState;
   dzPkg::arbState_t arbState;
   logic             rxClr;
   logic             txClr;

   // Request machine step, shared by rx and tx
   function automatic dzPkg::intState_t reqNext(dzPkg::intState_t cur, logic req,
                                                logic clr);
      dzPkg::intState_t nxt;
      nxt = cur;
      case (cur)
         dzPkg::intIdle: if (req) nxt = dzPkg::intAct;
         dzPkg::intAct:  if (clr) nxt = dzPkg::intWait;
         // Hold off until the source drops its request
         dzPkg::intWait: if (!req) nxt = dzPkg::intIdle;
         default:        nxt = dzPkg::intIdle;
      endcase
      return nxt;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Request machines
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rxState <= dzPkg::intIdle;
         txState <= dzPkg::intIdle;
      end
      else
      begin
         rxState <= reqNext(rxState, rxReq, rxClr);
         txState <= reqNext(txState, txReq, txClr);
      end
   end

   assign rxIrq = (rxState == dzPkg::intAct);
   assign txIrq = (txState == dzPkg::intAct);

   ////////////////////////////////////////////////////////////////////////////
   // Arbiter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         arbState <= dzPkg::arbIdle;
      else
      begin
         case (arbState)
            dzPkg::arbIdle:
               if (rxIrq || txIrq)
                  arbState <= dzPkg::arbAck;
            dzPkg::arbAck:
               if (intAck)
                  arbState <= dzPkg::arbVect;
            dzPkg::arbVect:
               if (intVect)
                  arbState <= dzPkg::arbVectClr;
            dzPkg::arbVectClr:
               // Vector cycle over, clear rx first
               if (!intVect)
               begin
                  if (rxIrq)
                     arbState <= dzPkg::arbRxDone;
                  else if (txIrq)
                     arbState <= dzPkg::arbTxDone;
               end
            default:
               arbState <= dzPkg::arbIdle;
         endcase
      end
   end

   assign rxClr = (arbState == dzPkg::arbRxDone);
   assign txClr = (arbState == dzPkg::arbTxDone);

   // A done state always has a request to clear
   assert property (@(posedge clk) disable iff (rst)
      (rxClr || txClr) |-> (rxIrq || txIrq));

endmodule

// File: dzRegs.sv
// APB slave with zero wait states; PREADY and PSLVERR are not provided
// Reads of TDR return zero, writes to RBUF are ignored
`timescale 1ns/1ns

module dzRegs
(
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       PSEL,
   input  logic                       PENABLE,
   input  logic                       PWRITE,
   input  logic [3:0]                 PADDR,
   input  logic [31:0]                PWDATA,
   output logic [31:0]                PRDATA,
   input  logic                       siloValid,
   input  logic [dzPkg::LineBits-1:0] siloLine,
   input  logic [dzPkg::CharBits-1:0] siloChar,
   input  logic                       siloOverrun,
   input  logic                       trdy,
   input  logic [dzPkg::LineBits-1:0] tline,
   output logic                       mse,
   output logic [dzPkg::NumLines-1:0] lineEnable,
   output logic                       rbufRead,
   output logic                       tdrWrite,
   output logic [dzPkg::CharBits-1:0] tdrChar,
   output logic                       rxReq,
   output logic                       txReq
);

   dzPkg::regAddr_t addr;
   logic            access;
   logic            wrAccess;
   logic            rdAccess;
   // CSR enables
   logic            rxIe;
   logic            txIe;

   ////////////////////////////////////////////////////////////////////////////
   // Decode
   ////////////////////////////////////////////////////////////////////////////

   assign addr     = dzPkg::regAddr_t'(PADDR[3:2]);
   // Access phase, always one cycle
   assign access   = PSEL && PENABLE;
   assign wrAccess = access && PWRITE;
   assign rdAccess = access && !PWRITE;

   // Pulses toward silo and scanner
   assign rbufRead = rdAccess && (addr == dzPkg::regRbuf);
   assign tdrWrite = wrAccess && (addr == dzPkg::regTdr);
   assign tdrChar  = PWDATA[dzPkg::CharBits-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // Writable registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rxIe       <= 1'b0;
         txIe       <= 1'b0;
         mse        <= 1'b0;
         lineEnable <= '0;
      end
      else if (wrAccess)
      begin
         case (addr)
            dzPkg::regCsr:
            begin
               // Status bits are read only
               txIe <= PWDATA[14];
               rxIe <= PWDATA[6];
               mse  <= PWDATA[5];
            end
            dzPkg::regTcr:
               lineEnable <= PWDATA[dzPkg::NumLines-1:0];
            default:
               lineEnable <= lineEnable;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      PRDATA = '0;
      case (addr)
         dzPkg::regCsr:
         begin
            PRDATA[15]                     = trdy;
            PRDATA[14]                     = txIe;
            PRDATA[8 +: dzPkg::LineBits]   = tline;
            // rdone mirrors silo not empty
            PRDATA[7]                      = siloValid;
            PRDATA[6]                      = rxIe;
            PRDATA[5]                      = mse;
         end
         dzPkg::regRbuf:
         begin
            PRDATA[15] = siloValid;
            PRDATA[14] = siloOverrun;
            // Line and char only for a real entry
            if (siloValid)
            begin
               PRDATA[8 +: dzPkg::LineBits]   = siloLine;
               PRDATA[dzPkg::CharBits-1:0]    = siloChar;
            end
         end
         dzPkg::regTcr:
            PRDATA[dzPkg::NumLines-1:0] = lineEnable;
         default:
            PRDATA = '0;
      endcase
   end

   // Interrupt requests
   assign rxReq = siloValid && rxIe;
   assign txReq = trdy && txIe;

   // APB access phase needs a select
   assert property (@(posedge clk) disable iff (rst) PENABLE |-> PSEL);

endmodule

// File: dzTop.sv
// Four-line multiplexer top; APB slave plus receive, transmit and interrupt
// Line serialization and vector generation live outside this block
`timescale 1ns/1ns

module dzTop
(
   input  logic                                        clk,
   input  logic                                        rst,
   // APB
   input  logic                                        PSEL,
   input  logic                                        PENABLE,
   input  logic                                        PWRITE,
   input  logic [3:0]                                  PADDR,
   input  logic [31:0]                                 PWDATA,
   output logic [31:0]                                 PRDATA,
   // Receive lines
   input  logic [dzPkg::NumLines-1:0]                  rxStrobe,
   input  logic [dzPkg::NumLines*dzPkg::CharBits-1:0]  rxData,
   // Transmit lines
   input  logic [dzPkg::NumLines-1:0]                  txReady,
   output logic [dzPkg::NumLines-1:0]                  txStrobe,
   output logic [dzPkg::CharBits-1:0]                  txData,
   // Interrupt bus
   input  logic                                        intAck,
   input  logic                                        intVect,
   output logic                                        rxIrq,
   output logic                                        txIrq
);

   // Shared control
   logic                       mse;
   logic [dzPkg::NumLines-1:0] lineEnable;
   // Silo side
   logic                       rbufRead;
   logic                       siloValid;
   logic [dzPkg::LineBits-1:0] siloLine;
   logic [dzPkg::CharBits-1:0] siloChar;
   logic                       siloOverrun;
   // Scanner side
   logic                       tdrWrite;
   logic [dzPkg::CharBits-1:0] tdrChar;
   logic                       trdy;
   logic [dzPkg::LineBits-1:0] tline;
   // Interrupt requests
   logic                       rxReq;
   logic                       txReq;

   dzRegs regs (
      .clk(clk), .rst(rst),
      .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
      .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
      .siloValid(siloValid), .siloLine(siloLine), .siloChar(siloChar),
      .siloOverrun(siloOverrun), .trdy(trdy), .tline(tline),
      .mse(mse), .lineEnable(lineEnable), .rbufRead(rbufRead),
      .tdrWrite(tdrWrite), .tdrChar(tdrChar), .rxReq(rxReq), .txReq(txReq)
   );

   dzSilo silo (
      .clk(clk), .rst(rst), .mse(mse),
      .rxStrobe(rxStrobe), .rxData(rxData), .rbufRead(rbufRead),
      .siloValid(siloValid), .siloLine(siloLine), .siloChar(siloChar),
      .siloOverrun(siloOverrun)
   );

   dzTxScan txScan (
      .clk(clk), .rst(rst), .mse(mse),
      .lineEnable(lineEnable), .txReady(txReady),
      .tdrWrite(tdrWrite), .tdrChar(tdrChar),
      .trdy(trdy), .tline(tline), .txStrobe(txStrobe), .txData(txData)
   );

   dzIntr intr (
      .clk(clk), .rst(rst),
      .rxReq(rxReq), .txReq(txReq),
      .intAck(intAck), .intVect(intVect),
      .rxIrq(rxIrq), .txIrq(txIrq)
   );

endmodule

// File: dzTb.sv
// Testbench for dzTop; inputs change on the falling edge, outputs sampled while stable
// Expected receive data comes from a queue model of the silo rules
`timescale 1ns/1ns

module dzTb;

   logic        clk = 1'b0;
   logic        rst;
   logic        PSEL;
   logic        PENABLE;
   logic        PWRITE;
   logic [3:0]  PADDR;
   logic [31:0] PWDATA;
   logic [31:0] PRDATA;
   logic [3:0]  rxStrobe;
   logic [31:0] rxData;
   logic [3:0]  txReady;
   logic [3:0]  txStrobe;
   logic [7:0]  txData;
   logic        intAck;
   logic        intVect;
   logic        rxIrq;
   logic        txIrq;

   // Bookkeeping
   integer      seed;
   int          errCount = 0;
   int          assertErrs = 0;
   int          timeouts = 0;
   // Silo model, entry is {line, char}
   logic [9:0]  expQ [$];
   logic        expOverrun = 1'b0;
   // Transmit side observations
   int          strobeCount = 0;
   logic [3:0]  lastStrobe = '0;
   logic [7:0]  lastTxData = '0;
   // Cycles since intVect last fell
   logic        prevVect = 1'b0;
   int          vectAge = 15;

   always #5 clk = ~clk;

   dzTop UUT (
      .clk(clk), .rst(rst),
      .PSEL(PSEL), .PENABLE(PENABLE), .PWRITE(PWRITE),
      .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
      .rxStrobe(rxStrobe), .rxData(rxData),
      .txReady(txReady), .txStrobe(txStrobe), .txData(txData),
      .intAck(intAck), .intVect(intVect), .rxIrq(rxIrq), .txIrq(txIrq)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Line model and monitors
   ////////////////////////////////////////////////////////////////////////////

   // A line goes busy once it is handed a character
   always @(negedge clk)
   begin
      if (|txStrobe)
      begin
         strobeCount++;
         lastStrobe = txStrobe;
         lastTxData = txData;
         txReady    = txReady & ~txStrobe;
      end
   end

   always @(posedge clk)
   begin
      if (prevVect && !intVect)
         vectAge <= 0;
      else if (vectAge < 15)
         vectAge <= vectAge + 1;
      prevVect <= intVect;
   end

   // Served irq drops two edges after the vector fall
   assert property (@(posedge clk) disable iff (rst)
      ($fell(rxIrq) || $fell(txIrq)) |-> (vectAge <= 2))
   else
   begin
      assertErrs++;
      $display("An interrupt request fell without a vector cycle before it");
   end

   // Transmit strobe is a single cycle
   assert property (@(posedge clk) disable iff (rst) (|txStrobe) |=> (txStrobe == 4'b0))
   else
   begin
      assertErrs++;
      $display("txStrobe stayed high for more than one cycle");
   end

   ////////////////////////////////////////////////////////////////////////////
   // Tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic writeReg(input dzPkg::regAddr_t r, input logic [31:0] d);
      @(negedge clk);
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      PWRITE  = 1'b1;
      PADDR   = {r, 2'b00};
      PWDATA  = d;
      @(negedge clk);
      PENABLE = 1'b1;
      @(negedge clk);
      PSEL    = 1'b0;
      PENABLE = 1'b0;
      PWRITE  = 1'b0;
   endtask

   task automatic readReg(input dzPkg::regAddr_t r, output logic [31:0] d);
      @(negedge clk);
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      PWRITE  = 1'b0;
      PADDR   = {r, 2'b00};
      @(negedge clk);
      PENABLE = 1'b1;
      // Read data settles well before the closing edge
      #2;
      d = PRDATA;
      @(negedge clk);
      PSEL    = 1'b0;
      PENABLE = 1'b0;
   endtask

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         errCount++;
         $display("ERR %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // One cycle of strobes, chars queued in ascending line order
   task automatic strobeLines(input logic [3:0] mask);
      integer     rnd;
      logic [7:0] ch;
      @(negedge clk);
      rxStrobe = mask;
      for (int n = 0; n < dzPkg::NumLines; n++)
      begin
         if (mask[n])
         begin
            rnd = $random(seed);
            ch  = rnd[7:0];
            rxData[n*8 +: 8] = ch;
            if (expQ.size() < dzPkg::SiloDepth)
               expQ.push_back({2'(n), ch});
            else
               expOverrun = 1'b1;
         end
      end
      @(negedge clk);
      rxStrobe = 4'b0;
   endtask

   task automatic checkRbuf();
      logic [31:0] got;
      logic [31:0] exp;
      logic [9:0]  ent;
      readReg(dzPkg::regRbuf, got);
      if (expQ.size() == 0)
         exp = {17'd0, expOverrun, 14'd0};
      else
      begin
         ent = expQ.pop_front();
         exp = {16'd0, 1'b1, expOverrun, 4'd0, ent[9:8], ent[7:0]};
         expOverrun = 1'b0;
      end
      checkValue("RBUF", got, exp);
   endtask

   // Polls CSR until the masked bits match
   task automatic waitCsr(input logic [31:0] mask, input logic [31:0] value,
                          input string what);
      logic [31:0] csr;
      int          tries;
      tries = 0;
      readReg(dzPkg::regCsr, csr);
      while (((csr & mask) != value) && (tries < 20))
      begin
         readReg(dzPkg::regCsr, csr);
         tries++;
      end
      if ((csr & mask) != value)
      begin
         timeouts++;
         $display("Timed out waiting for %s", what);
      end
   endtask

   // sel 0 watches rxIrq, sel 1 watches txIrq
   task automatic waitIrq(input int sel, input logic level, input string what);
      int cycles;
      cycles = 0;
      while (((sel == 0 ? rxIrq : txIrq) !== level) && (cycles < 40))
      begin
         @(negedge clk);
         cycles++;
      end
      if ((sel == 0 ? rxIrq : txIrq) !== level)
      begin
         timeouts++;
         $display("Timed out waiting for %s", what);
      end
   endtask

   task automatic waitTxStrobe(input int n);
      int cycles;
      cycles = 0;
      while ((strobeCount < n) && (cycles < 20))
      begin
         @(negedge clk);
         cycles++;
      end
      if (strobeCount < n)
      begin
         timeouts++;
         $display("Timed out waiting for a transmit strobe");
      end
   endtask

   // Acknowledge then vector, one cycle each
   task automatic vectorCycle();
      @(negedge clk);
      intAck  = 1'b1;
      @(negedge clk);
      intAck  = 1'b0;
      intVect = 1'b1;
      @(negedge clk);
      intVect = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      logic [31:0] csr;
      integer      rnd;
      logic [7:0]  ch;
      seed     = 31;
      rst      = 1'b1;
      PSEL     = 1'b0;
      PENABLE  = 1'b0;
      PWRITE   = 1'b0;
      PADDR    = 4'h0;
      PWDATA   = 32'h0;
      rxStrobe = 4'b0;
      rxData   = 32'h0;
      txReady  = 4'b0;
      intAck   = 1'b0;
      intVect  = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset state and readback
      checkValue("rxIrq", 32'(rxIrq), 32'h0);
      checkValue("txIrq", 32'(txIrq), 32'h0);
      checkValue("txStrobe", 32'(txStrobe), 32'h0);
      readReg(dzPkg::regCsr, csr);
      checkValue("CSR", csr, 32'h0);
      writeReg(dzPkg::regTcr, 32'hFFFF_FFF5);
      readReg(dzPkg::regTcr, csr);
      checkValue("TCR", csr, 32'h5);
      writeReg(dzPkg::regTcr, 32'h0);
      writeReg(dzPkg::regCsr, 32'hFFFF_FFFF);
      readReg(dzPkg::regCsr, csr);
      // tline wanders while nothing is enabled
      checkValue("CSR", csr & ~32'h300, 32'h4060);
      writeReg(dzPkg::regCsr, 32'h20);

      // Receive order, two lines in one cycle included
      strobeLines(4'b1000);
      strobeLines(4'b0010);
      strobeLines(4'b1010);
      waitCsr(32'h80, 32'h80, "rdone");
      repeat (5) checkRbuf();

      // Seventeen chars overflow the silo
      repeat (17) strobeLines(4'b0001);
      repeat (17) checkRbuf();

      // Transmit scan, only line 2 ready
      txReady = 4'b0100;
      writeReg(dzPkg::regTcr, 32'h5);
      waitCsr(32'h8300, 32'h8200, "trdy on line 2");
      readReg(dzPkg::regCsr, csr);
      checkValue("CSR", csr, 32'h8220);
      rnd = $random(seed);
      ch  = rnd[7:0];
      strobeCount = 0;
      writeReg(dzPkg::regTdr, 32'(ch));
      waitTxStrobe(1);
      repeat (3) @(negedge clk);
      checkValue("txStrobe count", 32'(strobeCount), 32'h1);
      checkValue("txStrobe", 32'(lastStrobe), 32'h4);
      checkValue("txData", 32'(lastTxData), 32'(ch));
      readReg(dzPkg::regCsr, csr);
      checkValue("CSR trdy", csr & 32'h8000, 32'h0);
      // Line 0 comes ready next
      txReady[0] = 1'b1;
      waitCsr(32'h8300, 32'h8000, "trdy on line 0");
      readReg(dzPkg::regCsr, csr);
      checkValue("CSR", csr, 32'h8020);

      // Both interrupts, receive served first
      writeReg(dzPkg::regCsr, 32'h4060);
      strobeLines(4'b0010);
      waitIrq(1, 1'b1, "txIrq");
      waitIrq(0, 1'b1, "rxIrq");
      vectorCycle();
      waitIrq(0, 1'b0, "rxIrq to drop");
      checkValue("txIrq", 32'(txIrq), 32'h1);
      checkRbuf();
      checkRbuf();
      vectorCycle();
      waitIrq(1, 1'b0, "txIrq to drop");
      checkValue("rxIrq", 32'(rxIrq), 32'h0);
      repeat (4) @(negedge clk);

      $display("Value errors: %0d, assertion failures: %0d, timeouts: %0d",
               errCount, assertErrs, timeouts);
      if ((errCount == 0) && (assertErrs == 0) && (timeouts == 0))
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: sim.f
dzPkg.sv
dzSilo.sv
dzTxScan.sv
dzIntr.sv
dzRegs.sv
dzTop.sv
dzTb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= dzTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
